// ==== common/cmd_pkg.sv ====
package cmd_pkg;

  // Header opcodes, carried in the top byte of the first word
  localparam logic [7:0] op_coordinated_step = 8'h01;
  localparam logic [7:0] op_motor_enable     = 8'h0a;
  localparam logic [7:0] op_clk_divisor      = 8'h20;
  localparam logic [7:0] op_api_version      = 8'hfe;

  localparam logic [7:0] version_major = 8'd1;
  localparam logic [7:0] version_minor = 8'd2;
  localparam logic [7:0] version_patch = 8'd3;
  localparam logic [7:0] version_devel = 8'd0;

  typedef struct packed {
    logic [7:0]  opcode;
    logic [7:0]  axis;     // Axis select field
    logic [47:0] payload;  // Masks and divisor sit in the low bits
  } cmd_header_t;

  // One host word, seen as a header or as raw data
  typedef union packed {
    cmd_header_t hdr;   // First word of a message
    logic [63:0] data;  // Duration, rate and acceleration words
  } cmd_word_u;

  typedef logic [63:0] reply_t;

  // Reply to the version read, patch in byte 0
  typedef struct packed {
    logic [31:0] rsvd;
    logic [7:0]  devel;
    logic [7:0]  major;
    logic [7:0]  minor;
    logic [7:0]  patch;
  } version_reply_t;

  localparam version_reply_t version_reply = '{
    rsvd:  32'd0,
    devel: version_devel,
    major: version_major,
    minor: version_minor,
    patch: version_patch
  };

endpackage

// ==== common/motion_pkg.sv ====
package motion_pkg;

  localparam int num_axes    = 2;
  localparam int buffer_size = 2;
  localparam int slot_bits   = 1;  // Width of a slot index

  localparam int duration_bits = 32;  // Move length in ticks
  localparam int rate_bits     = 64;
  localparam int frac_bits     = 32;  // Fractional part of rate and accumulator
  localparam int position_bits = 32;

  // Duration word plus a rate and an acceleration word per axis
  localparam int move_words = 1 + 2 * num_axes;

  localparam logic [7:0] default_divisor = 8'd32;

  typedef logic [num_axes-1:0] axis_mask_t;

  typedef logic signed [position_bits-1:0] position_t;

  // One axis's share of a move
  typedef struct packed {
    logic signed [rate_bits-1:0] rate;
    logic signed [rate_bits-1:0] accel;
  } axis_cfg_t;

  // A complete coordinated move as held in a buffer slot
  typedef struct packed {
    axis_mask_t                          dir;
    logic [duration_bits-1:0]            duration;
    logic [num_axes-1:0][rate_bits-1:0]  rate;
    logic [num_axes-1:0][rate_bits-1:0]  accel;
  } move_t;

endpackage

// ==== hdl/command_parser.sv ====
`timescale 1ns/1ps

module command_parser (
  input  logic                                            CLK,
  input  logic                                            resetn,
  input  cmd_pkg::cmd_word_u                              word_in,
  input  logic                                            word_strobe,
  input  motion_pkg::position_t [motion_pkg::num_axes-1:0] positions,
  output cmd_pkg::reply_t                                 reply_word,
  output motion_pkg::axis_mask_t                          enable,
  output logic [7:0]                                      divisor,
  output motion_pkg::move_t                               new_move,
  output logic                                            move_write
);
  import cmd_pkg::*;
  import motion_pkg::*;

  logic       strobe_q;
  logic       word_edge;
  logic [7:0] msg_header;  // Opcode of the message in progress
  logic [7:0] word_cnt;    // Words seen so far in this message
  logic       more_words;
  logic       in_move;

  position_t  snap [num_axes];  // Positions taken at the move header

  assign word_edge = word_strobe & ~strobe_q;

  // Only these headers are followed by data words
  assign more_words = (msg_header == op_coordinated_step) ||
                      (msg_header == op_api_version);
  assign in_move    = (msg_header == op_coordinated_step);

  // Control path, header tracking and reply
  always_ff @(posedge CLK) begin
    if (resetn) begin
      strobe_q   <= 1'b0;
      reply_word <= '0;
      enable     <= '0;
      divisor    <= default_divisor;
      msg_header <= '0;
      word_cnt   <= '0;
      move_write <= 1'b0;
    end else begin
      strobe_q   <= word_strobe;
      move_write <= 1'b0;

      if (word_edge) begin
        reply_word <= '0;  // Zero unless a branch below says otherwise

        if (!more_words) begin
          msg_header <= word_in.hdr.opcode;
          word_cnt   <= 8'd1;

          case (word_in.hdr.opcode)
            op_motor_enable: enable  <= word_in.hdr.payload[num_axes-1:0];
            op_clk_divisor:  divisor <= word_in.hdr.payload[7:0];
            op_api_version:  reply_word <= version_reply;
            default: ;
          endcase
        end else if (in_move) begin
          word_cnt <= word_cnt + 8'd1;

          // Duration word returns the first snapshot
          if (word_cnt == 8'd1)
            reply_word <= 64'(snap[0]);

          // Each acceleration word returns the next axis's snapshot
          for (int a = 0; a < num_axes - 1; a++) begin
            if (word_cnt == 8'(2 * a + 3))
              reply_word <= 64'(snap[a+1]);
          end

          if (word_cnt == 8'(move_words)) begin
            move_write <= 1'b1;  // Move complete, hand to buffer
            msg_header <= '0;
            word_cnt   <= '0;
          end
        end else begin
          // Trailing word of the version read
          msg_header <= '0;
          word_cnt   <= '0;
        end
      end
    end
  end

  // Move assembly and position snapshot
  always_ff @(posedge CLK) begin
    if (word_edge) begin
      if (!more_words) begin
        if (word_in.hdr.opcode == op_coordinated_step) begin
          new_move.dir <= word_in.hdr.payload[num_axes-1:0];
          for (int a = 0; a < num_axes; a++) begin
            snap[a] <= positions[a];
          end
        end
      end else if (in_move) begin
        if (word_cnt == 8'd1)
          new_move.duration <= word_in.data[duration_bits-1:0];

        // Rate then acceleration, axis by axis
        for (int a = 0; a < num_axes; a++) begin
          if (word_cnt == 8'(2 * a + 2))
            new_move.rate[a] <= word_in.data;
          if (word_cnt == 8'(2 * a + 3))
            new_move.accel[a] <= word_in.data;
        end
      end
    end
  end

endmodule

// ==== hdl/move_buffer.sv ====
`timescale 1ns/1ps

module move_buffer (
  input  logic                                CLK,
  input  logic                                resetn,
  input  motion_pkg::move_t                   new_move,
  input  logic                                move_write,
  input  logic [motion_pkg::slot_bits-1:0]    slot_index,
  input  logic [motion_pkg::buffer_size-1:0]  done_toggle,
  output logic [motion_pkg::buffer_size-1:0]  stepready,
  output motion_pkg::move_t                   active_move,
  output logic                                buffer_dtr
);
  import motion_pkg::*;

  move_t                slots [buffer_size];
  logic [slot_bits-1:0] wr_idx;
  logic [slot_bits-1:0] wr_idx_next;

  // Wrap at the last slot
  assign wr_idx_next = (wr_idx == slot_bits'(buffer_size - 1)) ? '0 : wr_idx + 1'b1;

  // Write index and ready toggles
  always_ff @(posedge CLK) begin
    if (resetn) begin
      wr_idx    <= '0;
      stepready <= '0;
    end else if (move_write) begin
      stepready[wr_idx] <= ~stepready[wr_idx];  // Hand the slot to the sequencer
      wr_idx            <= wr_idx_next;
    end
  end

  always_ff @(posedge CLK) begin
    if (move_write)
      slots[wr_idx] <= new_move;
  end

  assign active_move = slots[slot_index];

  // Slot is free once the sequencer has caught up with it
  assign buffer_dtr = (stepready[wr_idx] == done_toggle[wr_idx]);

endmodule

// ==== dda/dda_sequencer.sv ====
`timescale 1ns/1ps

module dda_sequencer (
  input  logic                                  CLK,
  input  logic                                  resetn,
  input  logic [7:0]                            divisor,
  input  logic [motion_pkg::buffer_size-1:0]    stepready,
  input  logic [motion_pkg::duration_bits-1:0]  move_duration,
  output logic                                  tick,
  output logic                                  load,
  output logic                                  executing,
  output logic                                  move_done,
  output logic [motion_pkg::slot_bits-1:0]      slot_index,
  output logic [motion_pkg::buffer_size-1:0]    done_toggle
);
  import motion_pkg::*;

  logic [7:0]               tick_cnt;
  logic [7:0]               tick_last;
  logic [duration_bits-1:0] remaining;  // Ticks left in the running move
  logic                     slot_ready;
  logic                     finish;
  logic [slot_bits-1:0]     next_slot;

  // A divisor of 0 runs like 1
  assign tick_last = (divisor == 8'd0) ? 8'd0 : divisor - 8'd1;

  // Tick divider
  always_ff @(posedge CLK) begin
    if (resetn) begin
      tick_cnt <= '0;
      tick     <= 1'b0;
    end else if (tick_cnt >= tick_last) begin  // Also catches a lowered divisor
      tick_cnt <= '0;
      tick     <= 1'b1;
    end else begin
      tick_cnt <= tick_cnt + 8'd1;
      tick     <= 1'b0;
    end
  end

  assign slot_ready = stepready[slot_index] ^ done_toggle[slot_index];
  assign load       = tick & ~executing & slot_ready;

  // Zero-length move ends at its load tick
  assign finish = (load && (move_duration == '0)) ||
                  (executing && tick && (remaining == duration_bits'(1)));

  assign next_slot = (slot_index == slot_bits'(buffer_size - 1)) ? '0 : slot_index + 1'b1;

  always_ff @(posedge CLK) begin
    if (resetn) begin
      executing   <= 1'b0;
      move_done   <= 1'b0;
      remaining   <= '0;
      slot_index  <= '0;
      done_toggle <= '0;
    end else begin
      move_done <= finish;

      if (load && (move_duration != '0)) begin
        executing <= 1'b1;
        remaining <= move_duration;
      end else if (executing && tick) begin
        remaining <= remaining - 1'b1;
        if (finish)
          executing <= 1'b0;
      end

      if (finish) begin
        done_toggle[slot_index] <= ~done_toggle[slot_index];  // Frees the slot
        slot_index              <= next_slot;
      end
    end
  end

endmodule

// ==== dda/dda_axis.sv ====
`timescale 1ns/1ps

module dda_axis (
  input  logic                  CLK,
  input  logic                  resetn,
  input  logic                  tick,
  input  logic                  load,
  input  logic                  executing,
  input  motion_pkg::axis_cfg_t cfg,
  input  logic                  dir_bit,
  output logic                  step,
  output motion_pkg::position_t position
);
  import motion_pkg::*;

  logic signed [rate_bits-1:0] acc;
  logic signed [rate_bits-1:0] rate_q;   // Running rate, grows by accel each tick
  logic signed [rate_bits-1:0] accel_q;
  logic signed [rate_bits-1:0] acc_sum;
  logic                        advance;
  logic                        crossed;

  assign advance = tick & executing;
  assign acc_sum = acc + rate_q;

  // Integer part moved on this add
  assign crossed = (acc_sum[rate_bits-1:frac_bits] != acc[rate_bits-1:frac_bits]);

  always_ff @(posedge CLK) begin
    if (load) begin
      acc     <= '0;
      rate_q  <= cfg.rate;
      accel_q <= cfg.accel;
    end else if (advance) begin
      acc    <= acc_sum;
      rate_q <= rate_q + accel_q;
    end
  end

  // Position taken with the step so dir still belongs to this move
  always_ff @(posedge CLK) begin
    if (resetn) begin
      step     <= 1'b0;
      position <= '0;
    end else begin
      step <= advance & crossed;
      if (advance && crossed)
        position <= dir_bit ? position + position_t'(1) : position - position_t'(1);
    end
  end

endmodule

// ==== hdl/stepper_controller_top.sv ====
`timescale 1ns/1ps

module stepper_controller_top (
  input  logic                   CLK,
  input  logic                   resetn,
  input  cmd_pkg::cmd_word_u     word_in,
  input  logic                   word_strobe,
  output cmd_pkg::reply_t        reply_word,
  output motion_pkg::axis_mask_t step,
  output motion_pkg::axis_mask_t dir,
  output motion_pkg::axis_mask_t enable,
  output logic                   buffer_dtr,
  output logic                   move_done
);
  import motion_pkg::*;

  logic [7:0]                   divisor;
  move_t                        new_move;
  logic                         move_write;
  move_t                        active_move;
  logic [buffer_size-1:0]       stepready;
  logic [buffer_size-1:0]       done_toggle;
  logic [slot_bits-1:0]         slot_index;
  logic                         tick;
  logic                         load;
  logic                         executing;
  position_t [num_axes-1:0]     positions;

  command_parser u_parser (
    .CLK        (CLK),
    .resetn     (resetn),
    .word_in    (word_in),
    .word_strobe(word_strobe),
    .positions  (positions),
    .reply_word (reply_word),
    .enable     (enable),
    .divisor    (divisor),
    .new_move   (new_move),
    .move_write (move_write)
  );

  move_buffer u_buffer (
    .CLK        (CLK),
    .resetn     (resetn),
    .new_move   (new_move),
    .move_write (move_write),
    .slot_index (slot_index),
    .done_toggle(done_toggle),
    .stepready  (stepready),
    .active_move(active_move),
    .buffer_dtr (buffer_dtr)
  );

  dda_sequencer u_seq (
    .CLK          (CLK),
    .resetn       (resetn),
    .divisor      (divisor),
    .stepready    (stepready),
    .move_duration(active_move.duration),
    .tick         (tick),
    .load         (load),
    .executing    (executing),
    .move_done    (move_done),
    .slot_index   (slot_index),
    .done_toggle  (done_toggle)
  );

  assign dir = active_move.dir;

  for (genvar i = 0; i < num_axes; i++) begin : g_axis
    axis_cfg_t cfg;

    assign cfg = '{rate: active_move.rate[i], accel: active_move.accel[i]};

    dda_axis u_axis (
      .CLK      (CLK),
      .resetn   (resetn),
      .tick     (tick),
      .load     (load),
      .executing(executing),
      .cfg      (cfg),
      .dir_bit  (active_move.dir[i]),
      .step     (step[i]),
      .position (positions[i])
    );
  end

endmodule

// ==== bench/stepper_chk.sv ====
`timescale 1ns/1ps

module stepper_chk (
  input logic                   CLK,
  input logic                   resetn,
  input motion_pkg::axis_mask_t step,
  input logic                   move_done,
  input logic                   move_write,
  input logic                   buffer_dtr
);
  import motion_pkg::*;

  for (genvar i = 0; i < num_axes; i++) begin : g_step
    step_pulse: assert property (@(posedge CLK) disable iff (resetn) step[i] |=> !step[i])
      else $error("step on axis %0d held longer than one cycle", i);
  end

  done_pulse: assert property (@(posedge CLK) disable iff (resetn) move_done |=> !move_done)
    else $error("move_done held longer than one cycle");

  // Writing into a pending slot would drop a move
  write_free: assert property (@(posedge CLK) disable iff (resetn) move_write |-> buffer_dtr)
    else $error("move written while buffer_dtr low");

  step_reset: assert property (@(posedge CLK) resetn |=> (step == '0))
    else $error("step not low after reset");

endmodule

bind stepper_controller_top stepper_chk chk0 (
  .CLK       (CLK),
  .resetn    (resetn),
  .step      (step),
  .move_done (move_done),
  .move_write(move_write),
  .buffer_dtr(buffer_dtr)
);

// ==== bench/tb_stepper.sv ====
`timescale 1ns/1ps

module tb_stepper;
  import cmd_pkg::*;
  import motion_pkg::*;

  localparam int unsigned wait_limit  = 20000;  // Cycles
  localparam int unsigned burst_moves = 6;

  // What one move should do on each axis
  typedef struct packed {
    axis_mask_t                dir;
    logic [num_axes-1:0][31:0] steps;
  } move_exp_t;

  logic       CLK;
  logic       resetn;
  cmd_word_u  word_in;
  logic       word_strobe;
  reply_t     reply_word;
  axis_mask_t step;
  axis_mask_t dir;
  axis_mask_t enable;
  logic       buffer_dtr;
  logic       move_done;

  logic [31:0] rng;
  move_exp_t   count_q [$];  // Consumed by the step monitor
  move_exp_t   pos_q [$];    // Consumed by the position model
  logic [31:0] step_cnt [num_axes];
  position_t   model_pos [num_axes];
  int unsigned done_count;
  int unsigned moves_sent;

  stepper_controller_top dut0 (
    .CLK        (CLK),
    .resetn     (resetn),
    .word_in    (word_in),
    .word_strobe(word_strobe),
    .reply_word (reply_word),
    .step       (step),
    .dir        (dir),
    .enable     (enable),
    .buffer_dtr (buffer_dtr),
    .move_done  (move_done)
  );

  always #20 CLK = ~CLK;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Integer part of the summed rate over all ticks of a move
  function automatic logic [31:0] expected_steps(input logic [63:0] rate,
                                                 input logic [63:0] accel,
                                                 input logic [31:0] ticks);
    logic [63:0] total;
    logic [63:0] r;
    total = 64'd0;
    r     = rate;
    for (int unsigned t = 0; t < ticks; t++) begin
      total = total + r;
      r     = r + accel;
    end
    return total[63:32];
  endfunction

  function automatic logic [63:0] widen_position(input position_t p);
    return {{(64 - position_bits){p[position_bits-1]}}, p};
  endfunction

  function automatic cmd_word_u make_header(input logic [7:0] opcode,
                                            input logic [47:0] payload);
    cmd_word_u w;
    w.hdr.opcode  = opcode;
    w.hdr.axis    = 8'd0;
    w.hdr.payload = payload;
    return w;
  endfunction

  function automatic cmd_word_u make_data(input logic [63:0] value);
    cmd_word_u w;
    w.data = value;
    return w;
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Test failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp)
      abort_run($sformatf("** Error: %s got 0x%h, expected 0x%h", name, got, exp));
  endtask

  // Called and left on a falling edge
  task automatic send_word(input cmd_word_u word, output reply_t reply);
    word_in     = word;
    word_strobe = 1'b1;
    repeat (3) @(negedge CLK);
    word_strobe = 1'b0;
    reply       = reply_word;  // Latched at the word edge
    repeat (3) @(negedge CLK);
  endtask

  task automatic wait_dtr();
    int unsigned n;
    n = 0;
    while (!buffer_dtr) begin
      @(negedge CLK);
      n++;
      if (n > wait_limit)
        abort_run("Timeout: buffer_dtr never went high");
    end
  endtask

  task automatic wait_all_done(input int unsigned limit);
    int unsigned n;
    n = 0;
    while (done_count != moves_sent) begin
      @(negedge CLK);
      n++;
      if (n > limit)
        abort_run($sformatf("Timeout: only %0d of %0d moves finished", done_count, moves_sent));
    end
    @(negedge CLK);  // Position model catches up
  endtask

  task automatic make_random_move(input logic [31:0] fixed_dur, output move_t mv);
    rng    = xorshift32(rng);
    mv.dir = rng[num_axes-1:0];
    rng    = xorshift32(rng);
    mv.duration = (fixed_dur != 32'd0) ? fixed_dur : (rng % 32'd40) + 32'd1;
    for (int a = 0; a < num_axes; a++) begin
      rng         = xorshift32(rng);
      mv.rate[a]  = {33'd0, rng[30:0]};   // Rate plus growth stays under 2^32
      rng         = xorshift32(rng);
      mv.accel[a] = {40'd0, rng[23:0]};
    end
  endtask

  // Snapshot replies are only predictable when no move is running
  task automatic send_move(input move_t mv, input bit check_snap);
    move_exp_t m;
    reply_t    reply;
    position_t snap_exp [num_axes];
    wait_dtr();
    m.dir = mv.dir;
    for (int a = 0; a < num_axes; a++) begin
      m.steps[a]  = expected_steps(mv.rate[a], mv.accel[a], mv.duration);
      snap_exp[a] = model_pos[a];
    end
    count_q.push_back(m);
    pos_q.push_back(m);
    moves_sent++;
    send_word(make_header(op_coordinated_step, 48'(mv.dir)), reply);
    check_val("reply_header", reply, 64'd0);
    send_word(make_data(64'(mv.duration)), reply);
    if (check_snap)
      check_val("reply_duration", reply, widen_position(snap_exp[0]));
    for (int a = 0; a < num_axes; a++) begin
      send_word(make_data(mv.rate[a]), reply);
      check_val($sformatf("reply_rate%0d", a), reply, 64'd0);
      send_word(make_data(mv.accel[a]), reply);
      if (a + 1 < num_axes) begin
        if (check_snap)
          check_val($sformatf("reply_accel%0d", a), reply, widen_position(snap_exp[a+1]));
      end else begin
        check_val($sformatf("reply_accel%0d", a), reply, 64'd0);
      end
    end
  endtask

  // Step monitor comparing per-axis counts at each move_done
  always @(negedge CLK) begin
    if (!resetn) begin
      for (int a = 0; a < num_axes; a++) begin
        step_cnt[a] = step_cnt[a] + 32'(step[a]);
        // The last step of a move comes with move_done and the next slot's dir
        if (step[a] && !move_done && count_q.size() != 0)
          check_val($sformatf("dir%0d", a), 64'(dir[a]), 64'(count_q[0].dir[a]));
      end
      if (move_done) begin
        if (count_q.size() == 0) begin
          abort_run("move_done pulsed with no move pending");
        end else begin
          for (int a = 0; a < num_axes; a++) begin
            check_val($sformatf("step_count%0d", a), 64'(step_cnt[a]),
                      64'(count_q[0].steps[a]));
            step_cnt[a] = 32'd0;
          end
          void'(count_q.pop_front());
          done_count++;
        end
      end
    end
  end

  // Position model
  always @(negedge CLK) begin
    if (!resetn && move_done && pos_q.size() != 0) begin
      for (int a = 0; a < num_axes; a++) begin
        if (pos_q[0].dir[a])
          model_pos[a] = model_pos[a] + position_t'(pos_q[0].steps[a]);
        else
          model_pos[a] = model_pos[a] - position_t'(pos_q[0].steps[a]);
      end
      void'(pos_q.pop_front());
    end
  end

  initial begin
    move_t       mv;
    reply_t      reply;
    axis_mask_t  mask;
    logic [7:0]  div;
    CLK         = 1'b0;
    resetn      = 1'b1;
    word_in     = '0;
    word_strobe = 1'b0;
    rng         = 32'd97;
    done_count  = 0;
    moves_sent  = 0;
    for (int a = 0; a < num_axes; a++) begin
      step_cnt[a]  = 32'd0;
      model_pos[a] = '0;
    end

    repeat (4) @(negedge CLK);
    resetn = 1'b0;
    @(negedge CLK);
    check_val("reply_word", reply_word, 64'd0);
    check_val("step", 64'(step), 64'd0);
    check_val("enable", 64'(enable), 64'd0);
    check_val("buffer_dtr", 64'(buffer_dtr), 64'd1);
    check_val("move_done", 64'(move_done), 64'd0);

    // Version read and its trailing word
    send_word(make_header(op_api_version, 48'd0), reply);
    check_val("reply_version", reply, 64'h0000_0000_0001_0203);
    rng = xorshift32(rng);
    send_word(make_data({rng, rng}), reply);
    check_val("reply_version_tail", reply, 64'd0);

    // Motor enable then an opcode the parser does not know
    rng  = xorshift32(rng);
    mask = rng[num_axes-1:0];
    send_word(make_header(op_motor_enable, 48'(mask)), reply);
    check_val("enable", 64'(enable), 64'(mask));
    check_val("reply_enable", reply, 64'd0);
    rng = xorshift32(rng);
    send_word(make_header(8'h5a, {16'd0, rng}), reply);
    check_val("reply_unknown", reply, 64'd0);

    make_random_move(32'd0, mv);
    send_move(mv, 1'b1);
    wait_all_done(wait_limit);

    // Burst where each header waits for a free slot
    for (int i = 0; i < burst_moves; i++) begin
      make_random_move(32'd0, mv);
      send_move(mv, 1'b0);
    end
    wait_all_done(wait_limit);

    // Snapshots must follow the positions reached so far
    for (int i = 0; i < 2; i++) begin
      make_random_move(32'd0, mv);
      send_move(mv, 1'b1);
      wait_all_done(wait_limit);
    end

    for (int i = 0; i < 2; i++) begin
      div = (i == 0) ? 8'd4 : 8'd40;
      send_word(make_header(op_clk_divisor, 48'(div)), reply);
      make_random_move(32'd25, mv);
      send_move(mv, 1'b1);
      wait_all_done(25 * 32'(div) + 2 * 32'(div) + 40);
    end

    $display("Test passed");
    $finish;
  end

endmodule

// ==== verilog.f ====
common/cmd_pkg.sv
common/motion_pkg.sv
hdl/command_parser.sv
hdl/move_buffer.sv
dda/dda_sequencer.sv
dda/dda_axis.sv
hdl/stepper_controller_top.sv
bench/stepper_chk.sv
bench/tb_stepper.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the stepper testbench with Verilator, run it, and scan the log

cd "$(dirname "$0")" || exit 1

log=sim.log
obj=obj_dir

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_stepper -f verilog.f --Mdir "$obj" -o tb_stepper_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$obj/tb_stepper_sim" > "$log" 2>&1
status=$?
cat "$log"

if grep -q "Test failed" "$log"; then
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi
exit 0
